// File: source/fetch_settings.svh
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// First fetch address after wake-up
`define FE_RESET_PC 32'h0000_0000

// Instruction queue entries, kept a power of two
`define FE_QUEUE_DEPTH 8

// Size code sent with every instruction fill
`define FE_FILL_SIZE 3'b100

// Bytes covered by one fill, also the pc step between fills
`define FE_LINE_BYTES 32'd16

`endif

// File: source/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

	// Request types toward the L1.5
	// Only the instruction miss is used by this front end
	typedef enum logic [4:0]
	{
		IMISS_RQ = 5'b10000
	} l15_rqtype_t;

	// Return types from the L1.5
	// IFILL_RET carries four instructions in data_0 and data_1
	// INT_RET is the wake-up interrupt after reset
	typedef enum logic [3:0]
	{
		IFILL_RET = 4'b0000,
		INT_RET   = 4'b0111
	} l15_rettype_t;

	// One instruction as seen by decode
	// Word sits in the upper half, pc in the lower half
	typedef struct packed
	{
		logic [31:0] word;
		logic [31:0] pc;
	} instr_rec_t;

endpackage

`default_nettype wire

// File: source/instr_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module instr_queue
#(
	parameter type         entry_t = fetch_pkg::instr_rec_t,
	parameter int unsigned DEPTH   = `FE_QUEUE_DEPTH,
	parameter int unsigned FREE_W  = $clog2(`FE_QUEUE_DEPTH + 1)
)
(
	input  logic              clk,
	input  logic              nrst,
	input  logic              push,
	input  entry_t            push_data,
	input  logic              pop,
	output logic              head_val,
	output entry_t            head_data,
	output logic [FREE_W-1:0] free_slots
);

	// Pointer width, depth is a power of two so pointers wrap freely
	localparam int unsigned AW = $clog2(DEPTH);

	entry_t            mem [DEPTH];

	logic [AW-1:0]     wr_ptr_q;
	logic [AW-1:0]     rd_ptr_q;
	logic [FREE_W-1:0] count_q;

	logic              empty;
	logic              full;
	logic              do_push;
	logic              do_pop;

	assign empty = (count_q == '0);
	assign full  = (count_q == FREE_W'(DEPTH));

	// Take while empty is dropped
	assign do_pop  = pop && !empty;
	assign do_push = push && !full;

	// Storage
	always_ff @(posedge clk)
	begin
		if (do_push)
		begin
			mem[wr_ptr_q] <= push_data;
		end
	end

	// Pointers and occupancy
	always_ff @(posedge clk)
	begin
		if (!nrst)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end
		else
		begin
			if (do_push)
			begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (do_pop)
			begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			// Simultaneous push and pop leaves count alone
			if (do_push && !do_pop)
			begin
				count_q <= count_q + 1'b1;
			end
			else if (do_pop && !do_push)
			begin
				count_q <= count_q - 1'b1;
			end
		end
	end

	// Head is visible as long as something is stored
	assign head_val   = !empty;
	assign head_data  = mem[rd_ptr_q];
	assign free_slots = FREE_W'(DEPTH) - count_q;

	// Producer side checks room before starting a fill
	a_no_push_full: assert property (
		@(posedge clk) disable iff (!nrst)
		push |-> !full
	) else $error("push into a full instruction queue");

endmodule

`default_nettype wire

// File: source/l15_response_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module l15_response_decoder
(
	input  logic                     clk,
	input  logic                     nrst,
	input  logic                     l15_val,
	input  fetch_pkg::l15_rettype_t  l15_returntype,
	input  logic [63:0]              l15_data_0,
	input  logic [63:0]              l15_data_1,
	input  logic [31:0]              fill_addr,
	output logic                     req_ack,
	output logic                     wake,
	output logic                     fill_done,
	output logic                     push,
	output fetch_pkg::instr_rec_t    push_rec
);

	// Registered response strobe and its type
	logic                    resp_val_q;
	fetch_pkg::l15_rettype_t resp_type_q;

	// Fill line waiting to be split, data_1 on top
	logic [127:0]            hold_q;

	// Serializer state
	logic                    busy_q;
	logic [1:0]              word_cnt_q;

	// Registered fill response, starts the serializer next cycle
	logic                    fill_load;

	assign fill_load = resp_val_q && (resp_type_q == fetch_pkg::IFILL_RET);

	// Capture the response strobe and type
	always_ff @(posedge clk)
	begin
		if (!nrst)
		begin
			resp_val_q <= 1'b0;
		end
		else
		begin
			resp_val_q <= l15_val;
		end
		resp_type_q <= l15_returntype;
	end

	// Fill data is latched straight from the response bus
	always_ff @(posedge clk)
	begin
		if (l15_val && (l15_returntype == fetch_pkg::IFILL_RET))
		begin
			hold_q <= {l15_data_1, l15_data_0};
		end
	end

	// Four pushes follow the ack cycle
	always_ff @(posedge clk)
	begin
		if (!nrst)
		begin
			busy_q     <= 1'b0;
			word_cnt_q <= 2'd0;
		end
		else if (fill_load)
		begin
			busy_q     <= 1'b1;
			word_cnt_q <= 2'd0;
		end
		else if (busy_q)
		begin
			word_cnt_q <= word_cnt_q + 2'd1;
			// Last word leaves this cycle
			if (word_cnt_q == 2'd3)
			begin
				busy_q <= 1'b0;
			end
		end
	end

	// Ack follows every response by one cycle
	assign req_ack = resp_val_q;

	// Interrupt return is the wake-up
	assign wake = resp_val_q && (resp_type_q == fetch_pkg::INT_RET);

	// Word order: data_0 low, data_0 high, data_1 low, data_1 high
	assign push          = busy_q;
	assign push_rec.word = hold_q[word_cnt_q*32 +: 32];
	assign push_rec.pc   = fill_addr + {28'd0, word_cnt_q, 2'b00};

	assign fill_done = busy_q && (word_cnt_q == 2'd3);

	// Holding register must not be overwritten before the line is split
	a_no_resp_while_busy: assert property (
		@(posedge clk) disable iff (!nrst)
		(fill_load || busy_q) |-> !l15_val
	) else $error("response arrived while a fill was being serialized");

endmodule

`default_nettype wire

// File: source/fetch_control.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module fetch_control
#(
	parameter int unsigned FREE_W = $clog2(`FE_QUEUE_DEPTH + 1)
)
(
	input  logic              clk,
	input  logic              nrst,
	input  logic              wake,
	input  logic              fill_done,
	input  logic              fill_sent,
	input  logic [FREE_W-1:0] free_slots,
	output logic              fill_start,
	output logic [31:0]       fill_addr
);

	// Words delivered by one fill
	localparam int unsigned FILL_WORDS = 4;

	typedef enum logic [1:0]
	{
		ST_ASLEEP,
		ST_READY,
		ST_REQUESTING,
		ST_AWAIT_DATA
	} fc_state_t;

	fc_state_t   state_q;
	fc_state_t   state_d;

	// Address of the next line to fetch
	logic [31:0] pc_q;

	// Room for a whole line, so a fill can never overrun the queue
	logic        room_ok;

	assign room_ok    = (free_slots >= FREE_W'(FILL_WORDS));
	assign fill_start = (state_q == ST_READY) && room_ok;
	assign fill_addr  = pc_q;

	// Next state
	always_comb
	begin
		state_d = state_q;
		case (state_q)
			ST_ASLEEP:
			begin
				// Nothing happens until the L1.5 wakes us
				if (wake)
				begin
					state_d = ST_READY;
				end
			end
			ST_READY:
			begin
				if (room_ok)
				begin
					state_d = ST_REQUESTING;
				end
			end
			ST_REQUESTING:
			begin
				// Request port is holding val
				if (fill_sent)
				begin
					state_d = ST_AWAIT_DATA;
				end
			end
			ST_AWAIT_DATA:
			begin
				// Last word pushed, line is done
				if (fill_done)
				begin
					state_d = ST_READY;
				end
			end
			default:
			begin
				state_d = ST_ASLEEP;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!nrst)
		begin
			state_q <= ST_ASLEEP;
			pc_q    <= `FE_RESET_PC;
		end
		else
		begin
			state_q <= state_d;
			// Step to the next line once this one is queued
			if ((state_q == ST_AWAIT_DATA) && fill_done)
			begin
				pc_q <= pc_q + `FE_LINE_BYTES;
			end
		end
	end

	// Only one fill in flight at a time
	a_sent_in_requesting: assert property (
		@(posedge clk) disable iff (!nrst)
		fill_sent |-> (state_q == ST_REQUESTING)
	) else $error("fill_sent without a request in flight");

	// Line completion belongs to the fill being awaited
	a_done_in_await: assert property (
		@(posedge clk) disable iff (!nrst)
		fill_done |-> (state_q == ST_AWAIT_DATA)
	) else $error("fill_done while no fill was awaited");

endmodule

`default_nettype wire

// File: source/l15_request_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module l15_request_port
(
	input  logic                    clk,
	input  logic                    nrst,
	input  logic                    fill_start,
	input  logic [31:0]             fill_addr,
	input  logic                    ack,
	output logic                    val,
	output fetch_pkg::l15_rqtype_t  rqtype,
	output logic [2:0]              size,
	output logic [31:0]             address,
	output logic [31:0]             data,
	output logic                    fill_sent
);

	// Latched fill address
	logic [31:0] addr_q;

	// Request valid, held until the L1.5 accepts it
	always_ff @(posedge clk)
	begin
		if (!nrst)
		begin
			val <= 1'b0;
		end
		else if (fill_start)
		begin
			val <= 1'b1;
		end
		else if (val && ack)
		begin
			val <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (fill_start)
		begin
			addr_q <= fill_addr;
		end
	end

	// Fixed fields of an instruction fill
	assign rqtype  = fetch_pkg::IMISS_RQ;
	assign size    = `FE_FILL_SIZE;
	// Fill carries no store data
	assign data    = 32'd0;
	assign address = addr_q;

	// Accepted in this cycle
	assign fill_sent = val && ack;

	// Waiting request keeps both val and address
	a_addr_stable: assert property (
		@(posedge clk) disable iff (!nrst)
		(val && !ack) |=> (val && $stable(address))
	) else $error("request dropped or address changed before ack");

endmodule

`default_nettype wire

// File: source/fetch_frontend.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module fetch_frontend
(
	input  logic                     clk,
	input  logic                     nrst,

	// L1.5 request
	output fetch_pkg::l15_rqtype_t   transducer_l15_rqtype,
	output logic [2:0]               transducer_l15_size,
	output logic [31:0]              transducer_l15_address,
	output logic [31:0]              transducer_l15_data,
	output logic                     transducer_l15_val,
	input  logic                     l15_transducer_ack,

	// L1.5 response
	input  logic                     l15_transducer_val,
	input  logic [63:0]              l15_transducer_data_0,
	input  logic [63:0]              l15_transducer_data_1,
	input  fetch_pkg::l15_rettype_t  l15_transducer_returntype,
	output logic                     transducer_l15_req_ack,

	// Decode
	output logic                     instr_val,
	output logic [31:0]              instr_word,
	output logic [31:0]              instr_pc,
	input  logic                     instr_take
);

	localparam int unsigned FREE_W = $clog2(`FE_QUEUE_DEPTH + 1);

	logic                  wake;
	logic                  fill_done;
	logic                  fill_start;
	logic                  fill_sent;
	logic [31:0]           fill_addr;
	logic [FREE_W-1:0]     free_slots;
	logic                  push;
	fetch_pkg::instr_rec_t push_rec;
	fetch_pkg::instr_rec_t head_rec;

	// Response side, splits fills into instructions
	l15_response_decoder i_l15_response_decoder
	(
		.clk            (clk),
		.nrst           (nrst),
		.l15_val        (l15_transducer_val),
		.l15_returntype (l15_transducer_returntype),
		.l15_data_0     (l15_transducer_data_0),
		.l15_data_1     (l15_transducer_data_1),
		.fill_addr      (fill_addr),
		.req_ack        (transducer_l15_req_ack),
		.wake           (wake),
		.fill_done      (fill_done),
		.push           (push),
		.push_rec       (push_rec)
	);

	// Fetch address and fill sequencing
	fetch_control #(.FREE_W(FREE_W)) i_fetch_control
	(
		.clk        (clk),
		.nrst       (nrst),
		.wake       (wake),
		.fill_done  (fill_done),
		.fill_sent  (fill_sent),
		.free_slots (free_slots),
		.fill_start (fill_start),
		.fill_addr  (fill_addr)
	);

	// Instructions waiting for decode
	instr_queue #(.entry_t(fetch_pkg::instr_rec_t), .FREE_W(FREE_W)) i_instr_queue
	(
		.clk        (clk),
		.nrst       (nrst),
		.push       (push),
		.push_data  (push_rec),
		.pop        (instr_take),
		.head_val   (instr_val),
		.head_data  (head_rec),
		.free_slots (free_slots)
	);

	// Request side toward the L1.5
	l15_request_port i_l15_request_port
	(
		.clk        (clk),
		.nrst       (nrst),
		.fill_start (fill_start),
		.fill_addr  (fill_addr),
		.ack        (l15_transducer_ack),
		.val        (transducer_l15_val),
		.rqtype     (transducer_l15_rqtype),
		.size       (transducer_l15_size),
		.address    (transducer_l15_address),
		.data       (transducer_l15_data),
		.fill_sent  (fill_sent)
	);

	assign instr_word = head_rec.word;
	assign instr_pc   = head_rec.pc;

endmodule

`default_nettype wire

// File: tests/l15_model.sv
`timescale 1ns/1ps
`default_nettype none

module l15_model
(
	input  logic                     clk,
	input  logic                     nrst,
	input  logic                     req_val,
	input  logic [31:0]              req_address,
	output logic                     req_ack,
	output logic                     resp_val,
	output fetch_pkg::l15_rettype_t  resp_returntype,
	output logic [63:0]              resp_data_0,
	output logic [63:0]              resp_data_1,
	input  logic                     resp_ack
);

	integer      seed;
	logic [31:0] line_addr;

	// Instruction i of a line is its own pc with 7'h33 in the low bits
	function automatic logic [31:0] fill_word(input logic [31:0] addr, input int idx);
		logic [31:0] pc;
		pc = addr + 32'(idx * 4);
		return {pc[31:7], 7'h33};
	endfunction

	// Uniform delay in lo..hi cycles
	function automatic int pick_delay(input int lo, input int hi);
		int r;
		r = $random(seed) & 32'h7fff_ffff;
		return lo + (r % (hi - lo + 1));
	endfunction

	// One-cycle response pulse, then wait for the front end to ack it
	task automatic send_response
	(
		input fetch_pkg::l15_rettype_t rtype,
		input logic [63:0]             d0,
		input logic [63:0]             d1
	);
		resp_val        = 1'b1;
		resp_returntype = rtype;
		resp_data_0     = d0;
		resp_data_1     = d1;
		@(posedge clk);
		#1;
		resp_val        = 1'b0;
		resp_returntype = fetch_pkg::IFILL_RET;
		resp_data_0     = 64'd0;
		resp_data_1     = 64'd0;
		while (!resp_ack)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	initial
	begin
		seed            = 32'hf7e6_0cfc;
		req_ack         = 1'b0;
		resp_val        = 1'b0;
		resp_returntype = fetch_pkg::IFILL_RET;
		resp_data_0     = 64'd0;
		resp_data_1     = 64'd0;
		line_addr       = 32'd0;
		@(posedge clk);
		while (!nrst)
		begin
			@(posedge clk);
		end
		#1;
		// Core sleeps for a while before the interrupt
		repeat (pick_delay(2, 9))
		begin
			@(posedge clk);
			#1;
		end
		send_response(fetch_pkg::INT_RET, 64'd0, 64'd0);
		forever
		begin
			while (!req_val)
			begin
				@(posedge clk);
				#1;
			end
			line_addr = req_address;
			// Request sits unacked for 0 to 3 cycles
			repeat (pick_delay(0, 3))
			begin
				@(posedge clk);
				#1;
			end
			req_ack = 1'b1;
			@(posedge clk);
			#1;
			req_ack = 1'b0;
			// Line comes back 1 to 4 cycles after the ack
			repeat (pick_delay(0, 3))
			begin
				@(posedge clk);
				#1;
			end
			send_response(fetch_pkg::IFILL_RET,
				{fill_word(line_addr, 1), fill_word(line_addr, 0)},
				{fill_word(line_addr, 3), fill_word(line_addr, 2)});
		end
	end

endmodule

`default_nettype wire

// File: tests/tb_fetch_frontend.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module tb_fetch_frontend;

	localparam int NUM_FILLS   = 24;
	localparam int NUM_INSTR   = NUM_FILLS * 4;
	// Takes before decode stalls, and the stall length
	localparam int HOLD_AFTER  = 30;
	localparam int HOLD_CYCLES = 40;
	// Slow fill is near 20 cycles, a fourfold margin per fill plus wake-up
	localparam int MAX_CYCLES  = NUM_FILLS * 80 + 80;

	logic                    clk;
	logic                    nrst;
	logic                    instr_take;

	fetch_pkg::l15_rqtype_t  transducer_l15_rqtype;
	logic [2:0]              transducer_l15_size;
	logic [31:0]             transducer_l15_address;
	logic [31:0]             transducer_l15_data;
	logic                    transducer_l15_val;
	logic                    l15_transducer_ack;
	logic                    l15_transducer_val;
	logic [63:0]             l15_transducer_data_0;
	logic [63:0]             l15_transducer_data_1;
	fetch_pkg::l15_rettype_t l15_transducer_returntype;
	logic                    transducer_l15_req_ack;
	logic                    instr_val;
	logic [31:0]             instr_word;
	logic [31:0]             instr_pc;

	integer      seed;
	int          errors;
	int          takes;
	int          pending_words;
	int          cycles;
	logic        woken;
	logic        hold_done;
	logic [31:0] exp_req_addr;
	logic [31:0] exp_pc;
	logic [31:0] exp_word;

	// Expected word for the next pc handed to decode
	assign exp_word = {exp_pc[31:7], 7'h33};

	fetch_frontend i_fetch_frontend
	(
		.clk                       (clk),
		.nrst                      (nrst),
		.transducer_l15_rqtype     (transducer_l15_rqtype),
		.transducer_l15_size       (transducer_l15_size),
		.transducer_l15_address    (transducer_l15_address),
		.transducer_l15_data       (transducer_l15_data),
		.transducer_l15_val        (transducer_l15_val),
		.l15_transducer_ack        (l15_transducer_ack),
		.l15_transducer_val        (l15_transducer_val),
		.l15_transducer_data_0     (l15_transducer_data_0),
		.l15_transducer_data_1     (l15_transducer_data_1),
		.l15_transducer_returntype (l15_transducer_returntype),
		.transducer_l15_req_ack    (transducer_l15_req_ack),
		.instr_val                 (instr_val),
		.instr_word                (instr_word),
		.instr_pc                  (instr_pc),
		.instr_take                (instr_take)
	);

	// Plays the L1.5 cache toward the front end
	l15_model i_l15_model
	(
		.clk             (clk),
		.nrst            (nrst),
		.req_val         (transducer_l15_val),
		.req_address     (transducer_l15_address),
		.req_ack         (l15_transducer_ack),
		.resp_val        (l15_transducer_val),
		.resp_returntype (l15_transducer_returntype),
		.resp_data_0     (l15_transducer_data_0),
		.resp_data_1     (l15_transducer_data_1),
		.resp_ack        (transducer_l15_req_ack)
	);

	task automatic log_failure(input string msg);
		errors = errors + 1;
		$display("[FAIL] %0t: %s", $time, msg);
	endtask

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#2 clk = ~clk;
		end
	end

	// Reference state: next request address, next pc, words in flight or queued
	always @(posedge clk)
	begin
		if (!nrst)
		begin
			woken         <= 1'b0;
			exp_req_addr  <= `FE_RESET_PC;
			exp_pc        <= `FE_RESET_PC;
			pending_words <= 0;
			takes         <= 0;
		end
		else
		begin
			if (l15_transducer_val && (l15_transducer_returntype == fetch_pkg::INT_RET))
			begin
				woken <= 1'b1;
			end
			if (transducer_l15_val && l15_transducer_ack)
			begin
				exp_req_addr <= exp_req_addr + 32'd16;
			end
			if (instr_val && instr_take)
			begin
				exp_pc <= exp_pc + 32'd4;
				takes  <= takes + 1;
			end
			// Fill words count from the response, takes from decode
			pending_words <= pending_words
				+ ((l15_transducer_val && (l15_transducer_returntype == fetch_pkg::IFILL_RET))
					? 4 : 0)
				- ((instr_val && instr_take) ? 1 : 0);
		end
	end

	a_sleep_quiet: assert property (@(posedge clk) disable iff (!nrst)
		!woken |-> (!transducer_l15_val && !instr_val))
		else log_failure("request or instruction before wake-up");

	a_req_fields: assert property (@(posedge clk) disable iff (!nrst)
		transducer_l15_val |-> (transducer_l15_rqtype == fetch_pkg::IMISS_RQ
			&& transducer_l15_size == `FE_FILL_SIZE && transducer_l15_data == 32'd0))
		else log_failure("request type, size or data wrong");

	a_req_addr: assert property (@(posedge clk) disable iff (!nrst)
		transducer_l15_val |-> (transducer_l15_address == exp_req_addr))
		else log_failure("request address out of sequence");

	a_req_hold: assert property (@(posedge clk) disable iff (!nrst)
		(transducer_l15_val && !l15_transducer_ack) |=> (transducer_l15_val
			&& $stable(transducer_l15_address) && $stable(transducer_l15_rqtype)
			&& $stable(transducer_l15_size)))
		else log_failure("request changed before ack");

	a_req_drop: assert property (@(posedge clk) disable iff (!nrst)
		(transducer_l15_val && l15_transducer_ack) |=> !transducer_l15_val)
		else log_failure("request val still high after ack");

	a_resp_acked: assert property (@(posedge clk) disable iff (!nrst)
		l15_transducer_val |=> transducer_l15_req_ack)
		else log_failure("response not acked in the next cycle");

	a_ack_has_resp: assert property (@(posedge clk) disable iff (!nrst)
		transducer_l15_req_ack |-> $past(l15_transducer_val))
		else log_failure("req_ack without a response the cycle before");

	a_take_order: assert property (@(posedge clk) disable iff (!nrst)
		(instr_val && instr_take) |-> (instr_pc == exp_pc && instr_word == exp_word))
		else log_failure("instruction pc or word out of order");

	a_queue_bound: assert property (@(posedge clk) disable iff (!nrst)
		pending_words <= `FE_QUEUE_DEPTH)
		else log_failure("more instructions delivered than the queue holds");

	// Request only rises when the queue had room for a whole line
	a_room_before_req: assert property (@(posedge clk) disable iff (!nrst)
		$rose(transducer_l15_val) |-> ($past(pending_words) <= `FE_QUEUE_DEPTH - 4))
		else log_failure("request raised with fewer than four free slots");

	initial
	begin
		cycles = 0;
		while (cycles < MAX_CYCLES)
		begin
			@(posedge clk);
			cycles = cycles + 1;
		end
		$display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial
	begin
		seed       = 32'hf7e6_0cfc;
		errors     = 0;
		hold_done  = 1'b0;
		nrst       = 1'b0;
		instr_take = 1'b0;
		repeat (2)
		begin
			@(posedge clk);
		end
		#1;
		nrst = 1'b1;
		while (takes < NUM_INSTR)
		begin
			if (!hold_done && (takes >= HOLD_AFTER))
			begin
				// Decode stalls, queue fills and fetch must pause
				instr_take = 1'b0;
				repeat (HOLD_CYCLES)
				begin
					@(posedge clk);
				end
				#1;
				hold_done = 1'b1;
			end
			instr_take = (($random(seed) & 3) != 0);
			@(posedge clk);
			#1;
		end
		instr_take = 1'b0;
		repeat (4)
		begin
			@(posedge clk);
		end
		$display("Summary: %0d errors, %0d instructions taken", errors, takes);
		if (errors == 0)
		begin
			$display("ALL TESTS PASSED");
		end
		else
		begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
+incdir+source
source/fetch_pkg.sv
source/instr_queue.sv
source/l15_response_decoder.sv
source/fetch_control.sv
source/l15_request_port.sv
source/fetch_frontend.sv
tests/l15_model.sv
tests/tb_fetch_frontend.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the fetch front end testbench with Verilator
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_fetch_frontend \
	-f build.f -o sim_fetch_frontend > "$LOG" 2>&1 &&
./obj_dir/sim_fetch_frontend >> "$LOG" 2>&1 ||
echo "SOME TESTS FAILED" >> "$LOG"

cat "$LOG"
grep -q "SOME TESTS FAILED" "$LOG" && exit 1 || exit 0
